// File: Makefile
# Verilator build and run for the cpuCore testbench
VERILATOR   ?= verilator
TOP         := cpuCore_tb
FILELIST    := all.f
BUILD_FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS  := --lint-only --timing -Wall
OBJ_DIR     := obj_dir
LOG         := sim.log
FAIL_MSG    := Simulation finished: FAIL
SOURCES     := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Failure when the log holds the fail message or the simulator exits nonzero
run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+source
source/cpu_pkg.sv
source/fetchLink.sv
source/instrFetch.sv
source/fetchQueue.sv
source/instrDecode.sv
source/executeUnit.sv
source/cpuCore.sv
verification/cpuCore_assertions.sv
verification/cpuCore_tb.sv

// File: source/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
  input wire clk,
  input wire rstN,
  output cpu_pkg::word_t imemAddr,
  input wire cpu_pkg::instr_t imemData,
  output logic wbValid,
  output cpu_pkg::regAddr_t wbReg,
  output cpu_pkg::word_t wbData,
  output logic halted
);

  // Redirect from execute back to fetch
  logic redirectValid;
  cpu_pkg::word_t redirectAddr;

  // Producer to FIFO, FIFO to consumer
  fetchLink fetchToQueue ();
  fetchLink queueToExec ();

  instrFetch fetch0 (
    .clk(clk),
    .rstN(rstN),
    .link(fetchToQueue.src),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .redirectValid(redirectValid),
    .redirectAddr(redirectAddr)
  );

  fetchQueue queue0 (
    .clk(clk),
    .rstN(rstN),
    .inLink(fetchToQueue.dst),
    .outLink(queueToExec.src)
  );

  executeUnit exec0 (
    .clk(clk),
    .rstN(rstN),
    .link(queueToExec.dst),
    .redirectValid(redirectValid),
    .redirectAddr(redirectAddr),
    .wbValid(wbValid),
    .wbReg(wbReg),
    .wbData(wbData),
    .halted(halted)
  );

endmodule

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

  // Plain vectors with a meaning
  typedef logic [`DATA_WIDTH-1:0] word_t;
  typedef logic [15:0] instr_t;
  typedef logic [3:0] regAddr_t;
  typedef logic [3:0] shamt_t;
  // Toggles on every redirect
  typedef logic epoch_t;

  // Top nibble of the instruction
  typedef enum logic [3:0] {
    opAdd = 4'h0, opAddz = 4'h1, opSub = 4'h2, opAnd = 4'h3,
    opNor = 4'h4, opSll = 4'h5, opSrl = 4'h6, opSra = 4'h7,
    opLw = 4'h8, opSw = 4'h9, opLhb = 4'ha, opLlb = 4'hb,
    opB = 4'hc, opJal = 4'hd, opJr = 4'he, opHlt = 4'hf
  } opcode_t;

  // ALU group uses the low three opcode bits directly
  typedef enum logic [2:0] {
    aluAdd = 3'b000, aluLhb = 3'b001, aluSub = 3'b010, aluAnd = 3'b011,
    aluNor = 3'b100, aluSll = 3'b101, aluSrl = 3'b110, aluSra = 3'b111
  } aluFunc_t;

  // Branch condition field, instr[11:9]
  typedef enum logic [2:0] {
    condNeq = 3'b000, condEq = 3'b001, condGt = 3'b010, condLt = 3'b011,
    condGte = 3'b100, condLte = 3'b101, condOvfl = 3'b110, condUncond = 3'b111
  } branchCond_t;

  // Four-phase handshake FSM states
  typedef enum logic [1:0] {
    idle = 2'b00, waitAck = 2'b01, waitRelease = 2'b10
  } linkState_t;

endpackage

`default_nettype wire

// File: source/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Width of a data word and of an instruction address
`define DATA_WIDTH 16

// Entries in the fetch FIFO
// Must be a power of two, at least 2
`define QUEUE_DEPTH 4

// Data memory size in words
// Addresses wrap modulo this size
`define DMEM_WORDS 256

// First instruction fetched after reset
`define RESET_ADDR 0

`endif

// File: source/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module executeUnit (
  input wire clk,
  input wire rstN,
  fetchLink.dst link,
  output logic redirectValid,
  output cpu_pkg::word_t redirectAddr,
  output logic wbValid,
  output cpu_pkg::regAddr_t wbReg,
  output cpu_pkg::word_t wbData,
  output logic halted
);

  localparam int dmemBits = $clog2(`DMEM_WORDS);
  localparam int msb = `DATA_WIDTH - 1;

  cpu_pkg::linkState_t state;
  cpu_pkg::epoch_t epoch;
  logic zrFlag, neFlag, ovFlag;
  cpu_pkg::word_t regs [16];
  cpu_pkg::word_t dmem [`DMEM_WORDS];

  cpu_pkg::word_t nextAddr;
  cpu_pkg::regAddr_t src0Addr, src1Addr, dstAddr;
  cpu_pkg::shamt_t shamt;
  cpu_pkg::aluFunc_t func;
  logic regWe, memWe, memToReg, src1Sel, jal, jr, hlt;

  cpu_pkg::opcode_t opcode;
  cpu_pkg::word_t src0, src1, imm, aluB, aluResult, wrData;
  logic [dmemBits-1:0] memIdx;
  logic fire, execute, setFlags, takeRedirect, ovAdd, ovSub;

  instrDecode decode0 (
    .instr(link.instr), .addr(link.addr),
    .zr(zrFlag), .ne(neFlag), .ov(ovFlag),
    .nextAddr(nextAddr), .src0Addr(src0Addr), .src1Addr(src1Addr),
    .dstAddr(dstAddr), .shamt(shamt), .func(func),
    .regWe(regWe), .memWe(memWe), .memToReg(memToReg), .src1Sel(src1Sel),
    .jal(jal), .jr(jr), .hlt(hlt)
  );

  assign opcode = cpu_pkg::opcode_t'(link.instr[15:12]);

  // Ack edge is the execute edge, stale epochs are acked and ignored
  assign fire = (state == cpu_pkg::idle) && link.req && !halted;
  assign execute = fire && (link.epoch == epoch);

  // R0 always reads zero
  assign src0 = (src0Addr == '0) ? '0 : regs[src0Addr];
  assign src1 = (src1Addr == '0) ? '0 : regs[src1Addr];

  // Byte loads put imm8 in the high byte, LW and SW use a signed nibble
  assign imm = link.instr[13] ? cpu_pkg::word_t'({link.instr[7:0], 8'h00}) :
                                cpu_pkg::word_t'($signed(link.instr[3:0]));
  assign aluB = src1Sel ? imm : src1;

  always_comb begin
    case (func)
      cpu_pkg::aluAdd: aluResult = src0 + aluB;
      // High byte from the immediate, low byte kept
      cpu_pkg::aluLhb: aluResult = {aluB[15:8], src0[7:0]};
      cpu_pkg::aluSub: aluResult = src0 - aluB;
      cpu_pkg::aluAnd: aluResult = src0 & aluB;
      cpu_pkg::aluNor: aluResult = ~(src0 | aluB);
      cpu_pkg::aluSll: aluResult = aluB << shamt;
      cpu_pkg::aluSrl: aluResult = aluB >> shamt;
      default: aluResult = cpu_pkg::word_t'($signed(aluB) >>> shamt);
    endcase
  end

  // Signed overflow
  assign ovAdd = (src0[msb] == aluB[msb]) && (aluResult[msb] != src0[msb]);
  assign ovSub = (src0[msb] != aluB[msb]) && (aluResult[msb] != src0[msb]);

  // ADDZ only counts when it actually writes
  assign setFlags = execute && ((opcode == cpu_pkg::opAdd) || (opcode == cpu_pkg::opSub) ||
                                (opcode == cpu_pkg::opAddz && zrFlag));

  // A branch to its own address reads as not taken
  assign takeRedirect = jal || jr || (opcode == cpu_pkg::opB && nextAddr != link.addr);

  // Address wraps modulo the memory size
  assign memIdx = aluResult[dmemBits-1:0];
  // JAL links to the following instruction
  assign wrData = jal ? link.addr + cpu_pkg::word_t'(1) :
                  memToReg ? dmem[memIdx] :
                  aluResult;

  always_ff @(posedge clk) begin
    if (execute) begin
      if (regWe && dstAddr != '0) regs[dstAddr] <= wrData;
      if (memWe) dmem[memIdx] <= src1;
      wbReg <= dstAddr;
      wbData <= wrData;
      redirectAddr <= jr ? src0 : nextAddr;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= cpu_pkg::idle;
      link.ack <= 1'b0;
      epoch <= 1'b0;
      {zrFlag, neFlag, ovFlag} <= 3'b000;
      redirectValid <= 1'b0;
      wbValid <= 1'b0;
      halted <= 1'b0;
    end else begin
      // Single-cycle pulses
      redirectValid <= 1'b0;
      wbValid <= 1'b0;
      case (state)
        cpu_pkg::idle: begin
          if (fire) begin
            link.ack <= 1'b1;
            state <= cpu_pkg::waitRelease;
          end
        end
        cpu_pkg::waitRelease: begin
          if (!link.req) begin
            link.ack <= 1'b0;
            state <= cpu_pkg::idle;
          end
        end
        default: state <= cpu_pkg::idle;
      endcase
      if (execute) begin
        wbValid <= regWe && (dstAddr != '0);
        // New epoch so anything already fetched gets dropped
        if (takeRedirect) begin
          redirectValid <= 1'b1;
          epoch <= ~epoch;
        end
        if (hlt) halted <= 1'b1;
      end
      if (setFlags) begin
        zrFlag <= (aluResult == '0);
        neFlag <= aluResult[msb];
        ovFlag <= (opcode == cpu_pkg::opSub) ? ovSub : ovAdd;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/fetchLink.sv
`timescale 1ns/1ps
`default_nettype none

// One four-phase instruction link
// Source raises req with payload stable, sink answers with ack
// Source drops req, then sink drops ack
interface fetchLink;

  logic req;
  logic ack;
  // Payload, held stable from req rise until ack is seen
  cpu_pkg::instr_t instr;
  cpu_pkg::word_t addr;
  cpu_pkg::epoch_t epoch;

  // Producer side
  modport src (
    output req,
    output instr,
    output addr,
    output epoch,
    input ack
  );

  // Consumer side
  modport dst (
    input req,
    input instr,
    input addr,
    input epoch,
    output ack
  );

endinterface

`default_nettype wire

// File: source/fetchQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module fetchQueue #(
  parameter int depth = `QUEUE_DEPTH
) (
  input wire clk,
  input wire rstN,
  fetchLink.dst inLink,
  fetchLink.src outLink
);

  localparam int ptrBits = $clog2(depth);
  localparam logic [ptrBits:0] fullCount = (ptrBits + 1)'(depth);

  // Entry storage
  cpu_pkg::instr_t instrMem [depth];
  cpu_pkg::word_t addrMem [depth];
  cpu_pkg::epoch_t epochMem [depth];

  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  // One bit wider than the pointers to tell full from empty
  logic [ptrBits:0] count;
  cpu_pkg::linkState_t inState;
  cpu_pkg::linkState_t outState;
  logic push;
  logic pop;

  // Accept only with a free slot, otherwise ack stays low
  assign push = (inState == cpu_pkg::idle) && inLink.req && (count != fullCount);
  // Head leaves when the consumer acknowledges it
  assign pop = (outState == cpu_pkg::waitAck) && outLink.ack;

  // Head stays put until popped, writes never hit it while nonempty
  assign outLink.instr = instrMem[rdPtr];
  assign outLink.addr = addrMem[rdPtr];
  assign outLink.epoch = epochMem[rdPtr];

  always_ff @(posedge clk) begin
    if (push) begin
      instrMem[wrPtr] <= inLink.instr;
      addrMem[wrPtr] <= inLink.addr;
      epochMem[wrPtr] <= inLink.epoch;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      inState <= cpu_pkg::idle;
      outState <= cpu_pkg::idle;
      inLink.ack <= 1'b0;
      outLink.req <= 1'b0;
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1;
      if (pop) rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase

      // Input side acks one cycle after req
      case (inState)
        cpu_pkg::idle: begin
          if (push) begin
            inLink.ack <= 1'b1;
            inState <= cpu_pkg::waitRelease;
          end
        end
        cpu_pkg::waitRelease: begin
          if (!inLink.req) begin
            inLink.ack <= 1'b0;
            inState <= cpu_pkg::idle;
          end
        end
        default: inState <= cpu_pkg::idle;
      endcase

      // Output side runs on its own
      case (outState)
        cpu_pkg::idle: begin
          if (count != '0) begin
            outLink.req <= 1'b1;
            outState <= cpu_pkg::waitAck;
          end
        end
        cpu_pkg::waitAck: begin
          if (outLink.ack) begin
            outLink.req <= 1'b0;
            outState <= cpu_pkg::waitRelease;
          end
        end
        cpu_pkg::waitRelease: begin
          if (!outLink.ack) outState <= cpu_pkg::idle;
        end
        default: outState <= cpu_pkg::idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module instrDecode (
  input wire cpu_pkg::instr_t instr,
  input wire cpu_pkg::word_t addr,
  input wire zr,
  input wire ne,
  input wire ov,
  output cpu_pkg::word_t nextAddr,
  output cpu_pkg::regAddr_t src0Addr,
  output cpu_pkg::regAddr_t src1Addr,
  output cpu_pkg::regAddr_t dstAddr,
  output cpu_pkg::shamt_t shamt,
  output cpu_pkg::aluFunc_t func,
  output logic regWe,
  output logic memWe,
  output logic memToReg,
  output logic src1Sel,
  output logic jal,
  output logic jr,
  output logic hlt
);

  cpu_pkg::opcode_t opcode;
  cpu_pkg::branchCond_t cond;
  cpu_pkg::word_t branchOffset;
  cpu_pkg::word_t jalOffset;
  logic isAlu;
  logic isBranch;
  logic isShift;
  logic taken;

  assign opcode = cpu_pkg::opcode_t'(instr[15:12]);
  assign cond = cpu_pkg::branchCond_t'(instr[11:9]);

  // Top bit clear means the ALU group
  assign isAlu = !instr[15];
  assign isBranch = (opcode == cpu_pkg::opB);
  assign isShift = (opcode == cpu_pkg::opSll) || (opcode == cpu_pkg::opSrl) ||
                   (opcode == cpu_pkg::opSra);
  assign jal = (opcode == cpu_pkg::opJal);
  assign jr = (opcode == cpu_pkg::opJr);
  assign hlt = (opcode == cpu_pkg::opHlt);

  // Condition against the flags, ne means the last result was negative
  always_comb begin
    case (cond)
      cpu_pkg::condNeq: taken = !zr;
      cpu_pkg::condEq: taken = zr;
      cpu_pkg::condGt: taken = !(zr || ne);
      cpu_pkg::condLt: taken = ne;
      cpu_pkg::condGte: taken = !ne;
      cpu_pkg::condLte: taken = ne || zr;
      cpu_pkg::condOvfl: taken = ov;
      cpu_pkg::condUncond: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Sign-extended offsets, relative to this instruction
  assign branchOffset = cpu_pkg::word_t'($signed(instr[8:0]));
  assign jalOffset = cpu_pkg::word_t'($signed(instr[11:0]));

  // Unchanged addr means fall through
  assign nextAddr = (isBranch && taken) ? addr + branchOffset :
                    jal ? addr + jalOffset :
                    addr;

  // LHB reads its own destination to keep the low byte
  assign src0Addr = (opcode == cpu_pkg::opLhb) ? instr[11:8] : instr[7:4];

  // Shifts take their operand on src1
  // SW puts the store data register on src1
  assign src1Addr = (opcode == cpu_pkg::opSw) ? instr[11:8] :
                    isShift ? instr[7:4] :
                    instr[3:0];

  // JAL links into R15, branches and a failed ADDZ go to R0
  assign dstAddr = jal ? 4'hf :
                   isBranch ? 4'h0 :
                   (opcode == cpu_pkg::opAddz && !zr) ? 4'h0 :
                   instr[11:8];

  // LLB shifts right arithmetically by a fixed 8
  assign shamt = isAlu ? instr[3:0] : 4'h8;

  assign regWe = jal || isAlu || (opcode == cpu_pkg::opLw) ||
                 (opcode == cpu_pkg::opLhb) || (opcode == cpu_pkg::opLlb);
  assign memWe = (opcode == cpu_pkg::opSw);
  assign memToReg = (opcode == cpu_pkg::opLw);

  // Immediate operand for loads, stores and byte loads
  assign src1Sel = instr[15];

  // ADDZ runs as an add, LW and SW add base and offset
  assign func = isAlu ? ((opcode == cpu_pkg::opAddz) ? cpu_pkg::aluAdd :
                         cpu_pkg::aluFunc_t'(instr[14:12])) :
                (opcode == cpu_pkg::opLhb) ? cpu_pkg::aluLhb :
                (opcode == cpu_pkg::opLlb) ? cpu_pkg::aluSra :
                cpu_pkg::aluAdd;

endmodule

`default_nettype wire

// File: source/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module instrFetch (
  input wire clk,
  input wire rstN,
  fetchLink.src link,
  output cpu_pkg::word_t imemAddr,
  input wire cpu_pkg::instr_t imemData,
  input wire redirectValid,
  input wire cpu_pkg::word_t redirectAddr
);

  cpu_pkg::linkState_t state;
  cpu_pkg::word_t pc;
  cpu_pkg::epoch_t epoch;
  logic capture;

  // Instruction memory answers in the same cycle
  assign imemAddr = pc;

  // Grab a new word when idle or once the last ack has dropped
  // A redirect in this cycle abandons the grab since pc is about to change
  assign capture = !redirectValid &&
                   ((state == cpu_pkg::idle) ||
                    (state == cpu_pkg::waitRelease && !link.ack));

  // Payload held on the link until the next capture
  always_ff @(posedge clk) begin
    if (capture) begin
      link.instr <= imemData;
      link.addr <= pc;
      link.epoch <= epoch;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= cpu_pkg::idle;
      link.req <= 1'b0;
      pc <= cpu_pkg::word_t'(`RESET_ADDR);
      epoch <= 1'b0;
    end else begin
      case (state)
        cpu_pkg::idle: begin
          if (capture) begin
            link.req <= 1'b1;
            state <= cpu_pkg::waitAck;
          end
        end
        cpu_pkg::waitAck: begin
          // A transfer in progress always completes
          if (link.ack) begin
            link.req <= 1'b0;
            state <= cpu_pkg::waitRelease;
          end
        end
        cpu_pkg::waitRelease: begin
          // Back to back offers when nothing redirects
          if (capture) begin
            link.req <= 1'b1;
            state <= cpu_pkg::waitAck;
          end else if (!link.ack) begin
            state <= cpu_pkg::idle;
          end
        end
        default: state <= cpu_pkg::idle;
      endcase
      // Redirect wins over the normal increment
      // An offer captured before a redirect carries the old epoch and leaves pc at the target
      if (redirectValid) begin
        pc <= redirectAddr;
        epoch <= ~epoch;
      end else if (state == cpu_pkg::waitAck && link.ack && link.epoch == epoch) begin
        pc <= pc + cpu_pkg::word_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/cpuCore_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

// Four-phase rules on both links of the fetch FIFO
// Payload is {instr, addr, epoch}
module handshakeChecks (
  input wire clk,
  input wire rstN,
  input wire inReq,
  input wire inAck,
  input wire [`DATA_WIDTH+16:0] inData,
  input wire outReq,
  input wire outAck,
  input wire [`DATA_WIDTH+16:0] outData
);

  // Source holds req until ack shows up
  inReqHeld: assert property (@(posedge clk) disable iff (!rstN)
    inReq && !inAck |=> inReq)
    else $error("fetchToQueue req dropped before ack");

  outReqHeld: assert property (@(posedge clk) disable iff (!rstN)
    outReq && !outAck |=> outReq)
    else $error("queueToExec req dropped before ack");

  // Sink answers only a pending request
  inAckRise: assert property (@(posedge clk) disable iff (!rstN)
    $rose(inAck) |-> inReq)
    else $error("fetchToQueue ack rose without req");

  outAckRise: assert property (@(posedge clk) disable iff (!rstN)
    $rose(outAck) |-> outReq)
    else $error("queueToExec ack rose without req");

  // Payload frozen while req stays up
  inDataStable: assert property (@(posedge clk) disable iff (!rstN)
    $past(inReq) && inReq |-> $stable(inData))
    else $error("fetchToQueue payload changed under req");

  outDataStable: assert property (@(posedge clk) disable iff (!rstN)
    $past(outReq) && outReq |-> $stable(outData))
    else $error("queueToExec payload changed under req");

endmodule

bind fetchQueue handshakeChecks handshakeChecks0 (
  .clk(clk),
  .rstN(rstN),
  .inReq(inLink.req),
  .inAck(inLink.ack),
  .inData({inLink.instr, inLink.addr, inLink.epoch}),
  .outReq(outLink.req),
  .outAck(outLink.ack),
  .outData({outLink.instr, outLink.addr, outLink.epoch})
);

`default_nettype wire

// File: verification/cpuCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpuCore_tb;

  logic clk;
  logic rstN;
  cpu_pkg::word_t imemAddr;
  cpu_pkg::instr_t imemData;
  logic wbValid;
  cpu_pkg::regAddr_t wbReg;
  cpu_pkg::word_t wbData;
  logic halted;

  // Program ROM indexed by the low address byte
  cpu_pkg::instr_t rom [256];
  int romLen;
  string testName;
  logic [31:0] lfsr;
  // Model state survives reset just like the DUT register file and data memory
  cpu_pkg::word_t mRegs [16];
  cpu_pkg::word_t mDmem [`DMEM_WORDS];
  cpu_pkg::word_t mPc;
  logic mZr;
  logic mNe;
  logic mOv;
  // Expected writebacks as {reg, data}
  logic [19:0] expQ [$];
  logic [19:0] expWb;

  cpuCore dut0 (
    .clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Instruction memory answers the current address
  always @(negedge clk) imemData <= rom[imemAddr[7:0]];

  task automatic abortRun(string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkReg(cpu_pkg::regAddr_t expected, cpu_pkg::regAddr_t actual);
    if (actual !== expected) begin
      abortRun($sformatf("ERR %s: wbReg expected %0d actual %0d", testName, expected, actual));
    end
  endtask

  task automatic checkWord(cpu_pkg::word_t expected, cpu_pkg::word_t actual);
    if (actual !== expected) begin
      abortRun($sformatf("ERR %s: wbData expected 0x%04h actual 0x%04h",
                         testName, expected, actual));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] nextLfsr(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit, up to 8 bits
  function automatic logic [7:0] randBits(int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = nextLfsr(lfsr);
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic clearRom();
    // Filler is LLB R1 with its own address, so a stray execute shows up
    for (int i = 0; i < 256; i++) begin
      rom[i] = {4'hb, 4'h1, 8'(i)};
    end
    romLen = 0;
  endtask

  task automatic addInstr(logic [3:0] op, logic [3:0] hi, logic [7:0] lo);
    rom[romLen] = {op, hi, lo};
    romLen++;
  endtask

  // Applies one instruction to the model, returns {valid, reg, data}
  function automatic logic [20:0] refExecute(cpu_pkg::instr_t ins);
    cpu_pkg::word_t pc0;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t r;
    cpu_pkg::word_t ea;
    cpu_pkg::regAddr_t rd;
    logic wr;
    logic taken;
    pc0 = mPc;
    mPc = pc0 + 16'd1;
    a = mRegs[ins[7:4]];
    b = mRegs[ins[3:0]];
    rd = ins[11:8];
    // Base plus signed nibble for LW and SW
    ea = a + {{12{ins[3]}}, ins[3:0]};
    wr = 1'b1;
    r = '0;
    taken = 1'b0;
    case (ins[15:12])
      4'h0, 4'h1, 4'h2: begin
        if (ins[15:12] == 4'h1 && !mZr) begin
          // ADDZ without zero flag does nothing
          wr = 1'b0;
        end else begin
          r = (ins[15:12] == 4'h2) ? a - b : a + b;
          mOv = (ins[15:12] == 4'h2) ? (a[15] != b[15] && r[15] != a[15]) :
                                       (a[15] == b[15] && r[15] != a[15]);
          mZr = (r == '0);
          mNe = r[15];
        end
      end
      4'h3: r = a & b;
      4'h4: r = ~(a | b);
      // Shifts take the register in bits 7:4 and amount in 3:0
      4'h5: r = a << ins[3:0];
      4'h6: r = a >> ins[3:0];
      4'h7: r = $signed(a) >>> ins[3:0];
      4'h8: r = mDmem[ea % `DMEM_WORDS];
      4'h9: begin
        mDmem[ea % `DMEM_WORDS] = mRegs[rd];
        wr = 1'b0;
      end
      4'ha: r = {ins[7:0], mRegs[rd][7:0]};
      4'hb: r = {{8{ins[7]}}, ins[7:0]};
      4'hc: begin
        wr = 1'b0;
        case (ins[11:9])
          3'd0: taken = !mZr;
          3'd1: taken = mZr;
          3'd2: taken = !mZr && !mNe;
          3'd3: taken = mNe;
          3'd4: taken = !mNe;
          3'd5: taken = mNe || mZr;
          3'd6: taken = mOv;
          default: taken = 1'b1;
        endcase
        if (taken) mPc = pc0 + {{7{ins[8]}}, ins[8:0]};
      end
      4'hd: begin
        // Link to the next instruction
        rd = 4'hf;
        r = pc0 + 16'd1;
        mPc = pc0 + {{4{ins[11]}}, ins[11:0]};
      end
      4'he: begin
        wr = 1'b0;
        mPc = a;
      end
      default: wr = 1'b0;
    endcase
    if (wr && rd != '0) mRegs[rd] = r;
    return {wr && (rd != '0), rd, r};
  endfunction

  task automatic buildExpected();
    int steps;
    logic [20:0] wb;
    expQ.delete();
    // Flags come out of reset cleared
    mZr = 1'b0;
    mNe = 1'b0;
    mOv = 1'b0;
    mPc = cpu_pkg::word_t'(`RESET_ADDR);
    steps = 0;
    while (rom[mPc[7:0]][15:12] != 4'hf) begin
      wb = refExecute(rom[mPc[7:0]]);
      if (wb[20]) expQ.push_back(wb[19:0]);
      steps++;
      if (steps > 1000) abortRun($sformatf("%s: reference model never reached HLT", testName));
    end
  endtask

  // Appends HLT, resets the DUT and waits for it to halt
  task automatic runProgram(string name);
    int waitCycles;
    testName = name;
    addInstr(4'hf, 4'h0, 8'h00);
    buildExpected();
    @(negedge clk);
    rstN = 1'b0;
    repeat (8) @(negedge clk);
    rstN = 1'b1;
    waitCycles = 0;
    while (!halted) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > 5000) abortRun($sformatf("%s: timeout waiting for halted", name));
    end
    // Quiet window, late writebacks are caught by the compare process
    waitCycles = 0;
    while (waitCycles < 100) begin
      @(negedge clk);
      waitCycles++;
      if (!halted) abortRun($sformatf("%s: halted dropped after HLT", name));
    end
    if (expQ.size() != 0) begin
      abortRun($sformatf("%s: halted with %0d writebacks missing", name, expQ.size()));
    end
  endtask

  always @(negedge clk) begin
    if (rstN && wbValid) begin
      if (expQ.size() == 0) begin
        abortRun($sformatf("%s: wbValid to R%0d with nothing expected", testName, wbReg));
      end else begin
        expWb = expQ.pop_front();
        checkReg(expWb[19:16], wbReg);
        checkWord(expWb[15:0], wbData);
      end
    end
  end

  initial begin : mainFlow
    logic [2:0] op;
    logic [3:0] off;
    rstN = 1'b0;
    imemData = '0;
    lfsr = 32'hb7de;
    for (int i = 0; i < 16; i++) mRegs[i] = '0;

    // Preload every register, then random ALU group work
    clearRom();
    for (int i = 1; i < 16; i++) begin
      addInstr(4'hb, 4'(i), randBits(8));
      addInstr(4'ha, 4'(i), randBits(8));
    end
    for (int i = 0; i < 60; i++) begin
      op = 3'(randBits(3));
      // No ADDZ here
      if (op == 3'd1) op = 3'd0;
      addInstr({1'b0, op}, 4'(randBits(4)), randBits(8));
    end
    runProgram("aluGroup");

    clearRom();
    addInstr(4'hb, 4'h1, 8'h85);
    addInstr(4'hb, 4'h2, 8'h7f);
    addInstr(4'ha, 4'h2, 8'ha5);
    // Zero result so the next ADDZ writes
    addInstr(4'h2, 4'h3, 8'h22);
    addInstr(4'h1, 4'h4, 8'h12);
    addInstr(4'h0, 4'h5, 8'h12);
    // Nonzero flag now, this ADDZ is silent
    addInstr(4'h1, 4'h6, 8'h11);
    for (int i = 0; i < 8; i++) begin
      op = 3'(randBits(1));
      addInstr({3'b101, op[0]}, 4'(randBits(4)), randBits(8));
    end
    runProgram("byteLoads");

    clearRom();
    for (int i = 0; i < 8; i++) begin
      // First pass forces a base that wraps past the top
      off = (i == 0) ? 4'h3 : 4'(randBits(4));
      addInstr(4'hb, 4'h1, (i == 0) ? 8'hff : randBits(8));
      addInstr(4'hb, 4'h2, randBits(8));
      addInstr(4'ha, 4'h2, randBits(8));
      addInstr(4'h9, 4'h2, {4'h1, off});
      // New high byte hits the same word modulo the memory size
      addInstr(4'ha, 4'h1, randBits(8));
      addInstr(4'h8, 4'h3, {4'h1, off});
    end
    runProgram("memory");

    clearRom();
    addInstr(4'hb, 4'h6, 8'd5);
    addInstr(4'hb, 4'h7, 8'd3);
    addInstr(4'hb, 4'h8, 8'h00);
    addInstr(4'ha, 4'h8, 8'h80);
    addInstr(4'hb, 4'h9, 8'd1);
    for (int c = 0; c < 8; c++) begin
      for (int s = 0; s < 4; s++) begin
        // Zero, negative, positive, signed overflow
        case (s)
          0: addInstr(4'h2, 4'h3, 8'h66);
          1: addInstr(4'h2, 4'h3, 8'h76);
          2: addInstr(4'h2, 4'h3, 8'h67);
          default: addInstr(4'h2, 4'h3, 8'h89);
        endcase
        // Forward by three skips two already fetched instructions
        addInstr(4'hc, {3'(c), 1'b0}, 8'd3);
        addInstr(4'hb, 4'h4, 8'(c * 4 + s));
        addInstr(4'hb, 4'h5, 8'(c * 4 + s));
        addInstr(4'hb, 4'hb, 8'(c * 4 + s));
      end
    end
    runProgram("branches");

    clearRom();
    addInstr(4'hb, 4'h1, randBits(8));
    // Call to address 5, return lands on address 2
    addInstr(4'hd, 4'h0, 8'd4);
    addInstr(4'hb, 4'h2, randBits(8));
    // Unconditional jump over the subroutine to the final HLT
    addInstr(4'hc, 4'he, 8'd6);
    addInstr(4'hb, 4'h4, 8'h44);
    addInstr(4'hb, 4'h5, randBits(8));
    addInstr(4'h0, 4'h6, 8'hf1);
    addInstr(4'he, 4'h0, 8'hf0);
    addInstr(4'hb, 4'h7, 8'h77);
    runProgram("jalJr");

    clearRom();
    addInstr(4'hb, 4'h1, randBits(8));
    addInstr(4'hb, 4'h2, randBits(8));
    addInstr(4'hf, 4'h0, 8'h00);
    // Everything past HLT must stay dead
    addInstr(4'hb, 4'h3, 8'h33);
    addInstr(4'h0, 4'h4, 8'h12);
    addInstr(4'h9, 4'h1, 8'h20);
    runProgram("halt");

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
